// File: project.f
+incdir+rtl
rtl/cpuPkg.sv
rtl/controlUnit.sv
rtl/fetchPath.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/memoryInterface.sv
rtl/cpuTop.sv
sim/clockGen.sv
sim/cpuTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f project.f -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// File: sim/cpu_vectors.mem
// Word 0 image length, word 1 output count, then the RAM image from address 0,
// then the expected outport values in strobe order
00000024  // 36 image words
0000000C  // 12 outputs
6100001E  // 00: addi r2, r0, 0x1E
01900000  // 01: ld   r3, 0(r2)
B9800000  // 02: out  r3
02100001  // 03: ld   r4, 1(r2)
BA000000  // 04: out  r4
60000003  // 05: addi r0, r0, 3
02800020  // 06: ld   r5, 0x20(r0)  r0 base reads zero
BA800000  // 07: out  r5
63180010  // 08: addi r6, r3, 0x10
BB000000  // 09: out  r6
1B9A0000  // 0A: add  r7, r3, r4
BB800000  // 0B: out  r7
24218000  // 0C: sub  r8, r4, r3
BC000000  // 0D: out  r8
2C9A0000  // 0E: and  r9, r3, r4
BC800000  // 0F: out  r9
35298000  // 10: or   r10, r5, r3
BD000000  // 11: out  r10
65A7FFFF  // 12: addi r11, r4, -1
BD800000  // 13: out  r11
66200020  // 14: addi r12, r4, 0x20  wraps
BE000000  // 15: out  r12
13900003  // 16: st   r7, 3(r2)
06900003  // 17: ld   r13, 3(r2)
BE800000  // 18: out  r13
14000022  // 19: st   r8, 0x22(r0)
07100004  // 1A: ld   r14, 4(r2)
BF000000  // 1B: out  r14
D8000000  // 1C: halt
B9800000  // 1D: out  r3  never reached
12345678  // 1E: data
FFFFFFF0  // 1F: data
0000BEEF  // 20: data
00000000  // 21: st target
00000000  // 22: st target through r0
DEADDEAD  // 23: hit only if r0 were added to the offset
12345678
FFFFFFF0
0000BEEF
12345688
12345668
EDCBA978
12345670
1234FEFF
FFFFFFEF
00000010
12345668
EDCBA978

// File: sim/cpuTb.sv
// CPU core testbench
`include "cpu_params.svh"

module cpuTb;
   localparam int VecDepth   = 256;
   localparam int HoldCycles = 20;
   localparam int Margin     = 50;

   logic               Clock;
   logic               rstN;
   logic               run;
   logic               progWe;
   logic [`ADDR_W-1:0] progAddr;
   logic [`DATA_W-1:0] progData;
   logic [`DATA_W-1:0] outPort;
   logic               outStrobe;
   logic               halted;

   logic [`DATA_W-1:0] vectors [VecDepth];
   int                 progLen;
   int                 expCount;
   int                 strobeCount;
   int                 passCount;
   int                 failCount;
   int                 cycleCount;
   int                 cycleLimit;
   int                 lowCount;
   bit                 timedOut;

   clockGen u_clock (
      .Clock (Clock),
      .rstN  (rstN)
   );

   cpuTop u_dut (
      .Clock     (Clock),
      .rstN      (rstN),
      .run       (run),
      .progWe    (progWe),
      .progAddr  (progAddr),
      .progData  (progData),
      .outPort   (outPort),
      .outStrobe (outStrobe),
      .halted    (halted)
   );

   // Word 0 is the image length, word 1 the strobe count
   task automatic readVectors();
      for (int i = 0; i < VecDepth; i++) begin
         vectors[i] = '0;
      end
      $readmemh("sim/cpu_vectors.mem", vectors);
      progLen  = int'(vectors[0]);
      expCount = int'(vectors[1]);
   endtask

   // Image goes to RAM address 0 upward while run is low
   task automatic loadProgram();
      for (int i = 0; i < progLen; i++) begin
         @(posedge Clock);
         #2;
         progWe   = 1'b1;
         progAddr = i[`ADDR_W-1:0];
         progData = vectors[2 + i];
      end
      @(posedge Clock);
      #2;
      progWe = 1'b0;
   endtask

   task automatic checkValue(input string what, input logic [`DATA_W-1:0] got,
                             input logic [`DATA_W-1:0] want);
      bit ok;
      ok = (got === want);
      assert (ok) else begin
         $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, want);
         failCount++;
      end
      if (ok) begin
         passCount++;
         $display("%s: %h as expected", what, got);
      end
   endtask

   task automatic checkCondition(input bit ok, input string passText, input string failText);
      assert (ok) else begin
         $display("%s", failText);
         failCount++;
      end
      if (ok) begin
         passCount++;
         $display("%s", passText);
      end
   endtask

   // Strobe is one cycle wide, so the falling edge sees each one once
   always @(negedge Clock) begin
      if (rstN && outStrobe) begin
         if (strobeCount < expCount) begin
            checkValue($sformatf("Output %0d", strobeCount + 1), outPort,
                       vectors[2 + progLen + strobeCount]);
         end else begin
            checkCondition(1'b0, "",
                           $sformatf("Unexpected output strobe with value %h after %0d outputs",
                                     outPort, expCount));
         end
         assert (!halted) else begin
            $display("Output strobe seen while the core reports halted");
            failCount++;
         end
         strobeCount++;
      end
   end

   initial begin
      run         = 1'b0;
      progWe      = 1'b0;
      progAddr    = '0;
      progData    = '0;
      strobeCount = 0;
      passCount   = 0;
      failCount   = 0;
      cycleCount  = 0;
      lowCount    = 0;
      timedOut    = 1'b0;

      readVectors();
      // Worst case is 8 cycles per word of the image
      cycleLimit = progLen * 8 + Margin;
      $display("Image of %0d words, %0d outputs expected", progLen, expCount);

      wait (rstN === 1'b1);
      loadProgram();
      @(posedge Clock);
      #2;
      run = 1'b1;

      while (!halted && !timedOut) begin
         @(negedge Clock);
         cycleCount++;
         if (!halted && cycleCount >= cycleLimit) begin
            timedOut = 1'b1;
         end
      end

      checkCondition(!timedOut,
                     $sformatf("Halt reached after %0d cycles", cycleCount),
                     $sformatf("Timeout: core did not halt within %0d cycles", cycleLimit));

      if (!timedOut) begin
         // Core must stay parked with no more output
         repeat (HoldCycles) begin
            @(negedge Clock);
            if (!halted) begin
               lowCount++;
            end
         end
         checkCondition(lowCount == 0,
                        $sformatf("Halted held for %0d cycles", HoldCycles),
                        $sformatf("Halted dropped during %0d of %0d cycles",
                                  lowCount, HoldCycles));
         checkCondition(strobeCount == expCount,
                        $sformatf("Output strobe count is %0d", strobeCount),
                        $sformatf("Wrong number of output strobes: saw %0d, expected %0d",
                                  strobeCount, expCount));
      end

      $display("Checks passed: %0d, failed: %0d", passCount, failCount);
      if (failCount == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

// File: sim/clockGen.sv
// Testbench clock and reset
module clockGen (
   output logic Clock,
   output logic rstN
);
   localparam int HalfPeriod  = 20;
   localparam int ResetCycles = 8;

   initial begin
      Clock = 1'b0;
      forever #HalfPeriod Clock = ~Clock;
   end

   // Release shortly after an edge, like the other inputs
   initial begin
      rstN = 1'b0;
      repeat (ResetCycles) @(posedge Clock);
      #2;
      rstN = 1'b1;
   end

endmodule

// File: rtl/cpuTop.sv
// Bus-based CPU core top level
`include "cpu_params.svh"

module cpuTop (
   input  logic               Clock,
   input  logic               rstN,
   input  logic               run,
   input  logic               progWe,
   input  logic [`ADDR_W-1:0] progAddr,
   input  logic [`DATA_W-1:0] progData,
   output logic [`DATA_W-1:0] outPort,
   output logic               outStrobe,
   output logic               halted
);
   import cpuPkg::*;

   instrWord           ir;
   busSrcT             busSrc;
   aluOpT              aluOp;
   logic [`DATA_W-1:0] bus;
   logic [`DATA_W-1:0] mdrData;
   logic [`DATA_W-1:0] regData;
   logic [`DATA_W-1:0] rzData;
   logic               pcIn;
   logic               incPc;
   logic               irIn;
   logic               marIn;
   logic               mdrIn;
   logic               memRead;
   logic               memWrite;
   logic               ryIn;
   logic               rzIn;
   logic               regIn;
   logic               gra;
   logic               grb;
   logic               grc;
   logic               baOut;
   logic               outIn;

   controlUnit u_control (
      .Clock    (Clock),
      .rstN     (rstN),
      .run      (run),
      .opcode   (ir.immFmt.opcode),
      .busSrc   (busSrc),
      .aluOp    (aluOp),
      .pcIn     (pcIn),
      .incPc    (incPc),
      .irIn     (irIn),
      .marIn    (marIn),
      .mdrIn    (mdrIn),
      .memRead  (memRead),
      .memWrite (memWrite),
      .ryIn     (ryIn),
      .rzIn     (rzIn),
      .regIn    (regIn),
      .gra      (gra),
      .grb      (grb),
      .grc      (grc),
      .baOut    (baOut),
      .outIn    (outIn),
      .halted   (halted)
   );

   fetchPath u_fetch (
      .Clock   (Clock),
      .rstN    (rstN),
      .pcIn    (pcIn),
      .incPc   (incPc),
      .irIn    (irIn),
      .busSrc  (busSrc),
      .mdrData (mdrData),
      .regData (regData),
      .rzData  (rzData),
      .bus     (bus),
      .ir      (ir)
   );

   registerFile u_regs (
      .Clock   (Clock),
      .rstN    (rstN),
      .regIn   (regIn),
      .gra     (gra),
      .grb     (grb),
      .grc     (grc),
      .baOut   (baOut),
      .ir      (ir),
      .bus     (bus),
      .regData (regData)
   );

   aluUnit u_alu (
      .Clock  (Clock),
      .rstN   (rstN),
      .ryIn   (ryIn),
      .rzIn   (rzIn),
      .aluOp  (aluOp),
      .bus    (bus),
      .rzData (rzData)
   );

   memoryInterface u_mem (
      .Clock    (Clock),
      .rstN     (rstN),
      .marIn    (marIn),
      .mdrIn    (mdrIn),
      .memRead  (memRead),
      .memWrite (memWrite),
      .run      (run),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .bus      (bus),
      .mdrData  (mdrData)
   );

   // Output port, strobe marks the cycle after the load
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         outPort   <= '0;
         outStrobe <= 1'b0;
      end else begin
         outStrobe <= outIn;
         if (outIn) begin
            outPort <= bus;
         end
      end
   end

endmodule

// File: rtl/memoryInterface.sv
// MAR, MDR and program RAM
`include "cpu_params.svh"

module memoryInterface (
   input  logic               Clock,
   input  logic               rstN,
   input  logic               marIn,
   input  logic               mdrIn,
   input  logic               memRead,
   input  logic               memWrite,
   input  logic               run,
   input  logic               progWe,
   input  logic [`ADDR_W-1:0] progAddr,
   input  logic [`DATA_W-1:0] progData,
   input  logic [`DATA_W-1:0] bus,
   output logic [`DATA_W-1:0] mdrData
);
   logic [`DATA_W-1:0] ram [`MEM_DEPTH];
   logic [`ADDR_W-1:0] mar;

   // Word address lives in the low bus bits
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         mar <= '0;
      end else if (marIn) begin
         mar <= bus[`ADDR_W-1:0];
      end
   end

   // A read takes priority over a bus load
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         mdrData <= '0;
      end else if (memRead) begin
         mdrData <= ram[mar];
      end else if (mdrIn) begin
         mdrData <= bus;
      end
   end

   // Program port only while the core is stopped
   always_ff @(posedge Clock) begin
      if (!run && progWe) begin
         ram[progAddr] <= progData;
      end else if (memWrite) begin
         ram[mar] <= mdrData;
      end
   end

endmodule

// File: rtl/aluUnit.sv
// ALU with RY and RZ registers
`include "cpu_params.svh"

module aluUnit (
   input  logic               Clock,
   input  logic               rstN,
   input  logic               ryIn,
   input  logic               rzIn,
   input  cpuPkg::aluOpT      aluOp,
   input  logic [`DATA_W-1:0] bus,
   output logic [`DATA_W-1:0] rzData
);
   import cpuPkg::*;

   logic [`DATA_W-1:0] ry;
   logic [`DATA_W-1:0] result;

   // First operand, held while the second one is on the bus
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         ry <= '0;
      end else if (ryIn) begin
         ry <= bus;
      end
   end

   // Add and sub simply drop the carry out
   always_comb begin
      case (aluOp)
         aluAdd:  result = ry + bus;
         aluSub:  result = ry - bus;
         aluAnd:  result = ry & bus;
         aluOr:   result = ry | bus;
         default: result = '0;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         rzData <= '0;
      end else if (rzIn) begin
         rzData <= result;
      end
   end

endmodule

// File: rtl/registerFile.sv
// General register file
`include "cpu_params.svh"

module registerFile (
   input  logic               Clock,
   input  logic               rstN,
   input  logic               regIn,
   input  logic               gra,
   input  logic               grb,
   input  logic               grc,
   input  logic               baOut,
   input  cpuPkg::instrWord   ir,
   input  logic [`DATA_W-1:0] bus,
   output logic [`DATA_W-1:0] regData
);
   localparam int SelW = $clog2(`REG_COUNT);

   logic [`DATA_W-1:0] regs [`REG_COUNT];
   logic [SelW-1:0]    sel;

   // Register number from the IR field picked by the sequencer
   always_comb begin
      if (gra) begin
         sel = ir.regFmt.ra;
      end else if (grb) begin
         sel = ir.regFmt.rb;
      end else if (grc) begin
         sel = ir.regFmt.rc;
      end else begin
         sel = '0;
      end
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         for (int i = 0; i < `REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (regIn) begin
         regs[sel] <= bus;
      end
   end

   // r0 as a base register gives absolute addressing
   assign regData = (baOut && sel == '0) ? '0 : regs[sel];

endmodule

// File: rtl/fetchPath.sv
// PC, IR and internal bus
`include "cpu_params.svh"

module fetchPath (
   input  logic                Clock,
   input  logic                rstN,
   input  logic                pcIn,
   input  logic                incPc,
   input  logic                irIn,
   input  cpuPkg::busSrcT      busSrc,
   input  logic [`DATA_W-1:0]  mdrData,
   input  logic [`DATA_W-1:0]  regData,
   input  logic [`DATA_W-1:0]  rzData,
   output logic [`DATA_W-1:0]  bus,
   output cpuPkg::instrWord    ir
);
   import cpuPkg::*;

   logic [`DATA_W-1:0] pc;
   logic [`DATA_W-1:0] immExt;

   // Word addressing, so the next instruction is pc + 1
   always_ff @(posedge Clock) begin
      if (!rstN) begin
         pc <= '0;
      end else if (pcIn) begin
         pc <= bus;
      end else if (incPc) begin
         pc <= pc + 1'b1;
      end
   end

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         ir <= '0;
      end else if (irIn) begin
         ir <= bus;
      end
   end

   // 19-bit constant field, sign extended
   assign immExt = {{(`DATA_W - 19){ir.immFmt.imm[18]}}, ir.immFmt.imm};

   always_comb begin
      case (busSrc)
         srcPc:   bus = pc;
         srcMdr:  bus = mdrData;
         srcReg:  bus = regData;
         srcRz:   bus = rzData;
         srcImm:  bus = immExt;
         default: bus = '0;
      endcase
   end

endmodule

// File: rtl/controlUnit.sv
// Hardwired control sequencer
`include "cpu_params.svh"

module controlUnit (
   input  logic           Clock,
   input  logic           rstN,
   input  logic           run,
   input  cpuPkg::opcodeT opcode,
   output cpuPkg::busSrcT busSrc,
   output cpuPkg::aluOpT  aluOp,
   output logic           pcIn,
   output logic           incPc,
   output logic           irIn,
   output logic           marIn,
   output logic           mdrIn,
   output logic           memRead,
   output logic           memWrite,
   output logic           ryIn,
   output logic           rzIn,
   output logic           regIn,
   output logic           gra,
   output logic           grb,
   output logic           grc,
   output logic           baOut,
   output logic           outIn,
   output logic           halted
);
   import cpuPkg::*;

   localparam logic [`STATE_W-1:0] sIdle = 0;
   localparam logic [`STATE_W-1:0] sT0   = 1;
   localparam logic [`STATE_W-1:0] sT1   = 2;
   localparam logic [`STATE_W-1:0] sT2   = 3;
   localparam logic [`STATE_W-1:0] sT3   = 4;
   localparam logic [`STATE_W-1:0] sT4   = 5;
   localparam logic [`STATE_W-1:0] sT5   = 6;
   localparam logic [`STATE_W-1:0] sT6   = 7;
   localparam logic [`STATE_W-1:0] sT7   = 8;
   localparam logic [`STATE_W-1:0] sHalt = 9;

   logic [`STATE_W-1:0] state;
   logic [`STATE_W-1:0] nextState;
   logic                isMem;
   logic                isRegAlu;
   logic                lastStep;
   aluOpT               aluSel;

   always_ff @(posedge Clock) begin
      if (!rstN) begin
         state <= sIdle;
      end else begin
         state <= nextState;
      end
   end

   // Instruction classes, only meaningful from T3 on
   assign isMem    = (opcode == opLd) || (opcode == opSt);
   assign isRegAlu = (opcode == opAdd) || (opcode == opSub) ||
                     (opcode == opAnd) || (opcode == opOr);

   always_comb begin
      case (opcode)
         opSub:   aluSel = aluSub;
         opAnd:   aluSel = aluAnd;
         opOr:    aluSel = aluOr;
         default: aluSel = aluAdd;
      endcase
   end

   // Final step of each instruction
   always_comb begin
      if (isMem) begin
         lastStep = (state == sT7);
      end else if (isRegAlu || opcode == opAddi) begin
         lastStep = (state == sT5);
      end else begin
         lastStep = (state == sT3);
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         sIdle: begin
            if (run) begin
               nextState = sT0;
            end
         end
         sT0: nextState = sT1;
         sT1: nextState = sT2;
         sT2: nextState = sT3;
         sT3, sT4, sT5, sT6, sT7: begin
            if (opcode == opHalt) begin
               nextState = sHalt;
            end else if (lastStep) begin
               nextState = run ? sT0 : sIdle;
            end else begin
               nextState = state + 1'b1;
            end
         end
         sHalt: nextState = sHalt;
         default: nextState = sIdle;
      endcase
   end

   // No jump instructions, so PC is only ever incremented
   assign pcIn = 1'b0;

   always_comb begin
      busSrc   = srcNone;
      aluOp    = aluAdd;
      incPc    = 1'b0;
      irIn     = 1'b0;
      marIn    = 1'b0;
      mdrIn    = 1'b0;
      memRead  = 1'b0;
      memWrite = 1'b0;
      ryIn     = 1'b0;
      rzIn     = 1'b0;
      regIn    = 1'b0;
      gra      = 1'b0;
      grb      = 1'b0;
      grc      = 1'b0;
      baOut    = 1'b0;
      outIn    = 1'b0;
      halted   = 1'b0;
      case (state)
         sT0: begin
            busSrc = srcPc;
            marIn  = 1'b1;
            incPc  = 1'b1;
         end
         sT1: begin
            memRead = 1'b1;
            mdrIn   = 1'b1;
         end
         sT2: begin
            busSrc = srcMdr;
            irIn   = 1'b1;
         end
         sT3: begin
            if (opcode == opOut) begin
               busSrc = srcReg;
               gra    = 1'b1;
               outIn  = 1'b1;
            end else if (opcode == opHalt) begin
               halted = 1'b1;
            end else if (isMem || isRegAlu || opcode == opAddi) begin
               // Base or first operand into RY; r0 as a base means zero
               busSrc = srcReg;
               grb    = 1'b1;
               baOut  = isMem;
               ryIn   = 1'b1;
            end
         end
         sT4: begin
            if (isRegAlu) begin
               busSrc = srcReg;
               grc    = 1'b1;
            end else begin
               busSrc = srcImm;
            end
            aluOp = aluSel;
            rzIn  = 1'b1;
         end
         sT5: begin
            busSrc = srcRz;
            if (isMem) begin
               marIn = 1'b1;
            end else begin
               gra   = 1'b1;
               regIn = 1'b1;
            end
         end
         sT6: begin
            if (opcode == opLd) begin
               memRead = 1'b1;
               mdrIn   = 1'b1;
            end else begin
               busSrc = srcReg;
               gra    = 1'b1;
               mdrIn  = 1'b1;
            end
         end
         sT7: begin
            if (opcode == opLd) begin
               busSrc = srcMdr;
               gra    = 1'b1;
               regIn  = 1'b1;
            end else begin
               memWrite = 1'b1;
            end
         end
         sHalt: halted = 1'b1;
         default: ;
      endcase
   end

endmodule

// File: rtl/cpuPkg.sv
// CPU core shared types
package cpuPkg;

   // Five-bit major opcodes
   typedef enum logic [4:0] {
      opLd   = 5'b00000,
      opSt   = 5'b00010,
      opAdd  = 5'b00011,
      opSub  = 5'b00100,
      opAnd  = 5'b00101,
      opOr   = 5'b00110,
      opAddi = 5'b01100,
      opOut  = 5'b10111,
      opHalt = 5'b11011
   } opcodeT;

   // ld, st, addi, out and halt
   typedef struct packed {
      opcodeT      opcode;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [18:0] imm;
   } immFormatT;

   // add, sub, and, or
   typedef struct packed {
      opcodeT      opcode;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [3:0]  rc;
      logic [14:0] unused;
   } regFormatT;

   // Same IR word seen through either format
   typedef union packed {
      immFormatT immFmt;
      regFormatT regFmt;
   } instrWord;

   typedef enum logic [2:0] {
      srcNone,
      srcPc,
      srcMdr,
      srcReg,
      srcRz,
      srcImm
   } busSrcT;

   typedef enum logic [1:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr
   } aluOpT;

endpackage

// File: rtl/cpu_params.svh
// CPU core sizing parameters
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Width of the internal bus and of every datapath register
`define DATA_W 32

// General purpose registers r0 to r15
`define REG_COUNT 16

// Word-addressed program and data RAM
`define MEM_DEPTH 256

// RAM address width; MAR keeps only these low bits of the bus
`define ADDR_W 8

// Sequencer state code width, enough for idle, T0..T7 and halt
`define STATE_W 4

`endif
